// ==== tb.f ====
logic/pkt_pkg.sv
logic/packet_writer.sv
logic/packet_mem.sv
logic/read_size_adapter.sv
logic/load_unit.sv
logic/packet_load_top.sv
bench/load_checker.sv
bench/tb_top.sv

// ==== bench/tb_top.sv ====
module tb_top;
    timeunit 1ns;
    timeprecision 1ps;
    import pkt_pkg::*;

    // Packet lengths in bytes for the three packets of the run
    localparam int PKT1_LEN = 64;
    localparam int PKT2_LEN = 30;
    localparam int PKT3_LEN = 48;
    localparam int N_BEATS  = (PKT1_LEN + 3) / 4 + (PKT2_LEN + 3) / 4 + (PKT3_LEN + 3) / 4;
    localparam int N_RANDOM = 300;
    // Directed loads cover aligned words, every offset, bounds, back-pressure and early loads
    localparam int N_LOADS  = 16 + 48 + 6 + 7 + 10 + 6 + N_RANDOM;
    localparam int CYCLE_LIMIT = 40 * (N_BEATS + N_LOADS) + 200;

    logic                  clk;
    logic                  arst_n;
    logic                  beat_valid;
    pkt_beat_t             beat;
    logic                  pkt_ready;
    logic [PKT_ADDR_W:0]   pkt_len;
    logic                  req_valid;
    load_req_t             req;
    logic                  req_credit;
    logic                  resp_credit;
    logic                  resp_valid;
    load_resp_t            resp;

    logic [31:0] rng;
    logic [31:0] credit_rng;
    // Credit return policy where 0 returns at once, 1 withholds and 2 returns at random
    int          credit_mode;
    logic        credit_give;
    int          slots_held;
    int          req_sent;
    int          req_returned = 0;
    int          resp_count = 0;
    int          cycle_count;
    int          bench_errors;
    int          chk_errors;
    int          chk_count;

    packet_load_top i_packet_load_top (
        .clk         (clk),
        .arst_n      (arst_n),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .pkt_ready   (pkt_ready),
        .pkt_len     (pkt_len),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp)
    );

    load_checker i_load_checker (
        .clk         (clk),
        .arst_n      (arst_n),
        .beat_valid  (beat_valid),
        .beat        (beat),
        .pkt_ready   (pkt_ready),
        .pkt_len     (pkt_len),
        .req_valid   (req_valid),
        .req         (req),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .errors      (chk_errors),
        .checks      (chk_count)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Returned request credits and finished loads as the client sees them
    always @(posedge clk) begin
        if (req_credit) begin
            req_returned++;
        end
        if (resp_valid) begin
            resp_count++;
        end
    end

    // Client response slots are each freed some time after their result arrives
    initial begin
        resp_credit = 1'b0;
        slots_held  = 0;
        credit_rng  = xorshift32(32'hc327);
        forever begin
            @(posedge clk);
            if (resp_valid) begin
                slots_held++;
            end
            #1;
            credit_give = 1'b0;
            if (slots_held > 0 && credit_mode == 0) begin
                credit_give = 1'b1;
            end else if (slots_held > 0 && credit_mode == 2) begin
                credit_rng  = xorshift32(credit_rng);
                credit_give = credit_rng[3];
            end
            resp_credit = credit_give;
            if (credit_give) begin
                slots_held--;
            end
        end
    end

    task automatic write_packet(input int len);
        int nbeats;
        int i;
        nbeats = (len + 3) / 4;
        for (i = 0; i < nbeats; i++) begin
            rng         = xorshift32(rng);
            beat_valid  = 1'b1;
            beat.data   = rng;
            beat.last   = (i == nbeats - 1);
            beat.nbytes = (i == nbeats - 1) ? 3'(len - 4 * i) : 3'd4;
            @(posedge clk);
            #1;
        end
        beat_valid = 1'b0;
        beat.last  = 1'b0;
    endtask

    // Spends one request credit and waits for one if none is left
    task automatic send_load(input int addr, input logic [1:0] size);
        while (req_sent - req_returned >= REQ_CREDITS) begin
            @(posedge clk);
            #1;
        end
        req_valid = 1'b1;
        req.addr  = PKT_ADDR_W'(addr);
        req.size  = size;
        req_sent++;
        @(posedge clk);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic wait_idle();
        while (resp_count != req_sent) begin
            @(posedge clk);
            #1;
        end
    endtask

    task automatic check_req_credits();
        if (REQ_CREDITS - (req_sent - req_returned) != REQ_CREDITS) begin
            bench_errors++;
            $display("Request credits did not all come back, %0d of %0d held",
                REQ_CREDITS - (req_sent - req_returned), REQ_CREDITS);
        end
    endtask

    initial begin
        int i;
        arst_n       = 1'b0;
        beat_valid   = 1'b0;
        beat         = '0;
        req_valid    = 1'b0;
        req          = '0;
        credit_mode  = 0;
        req_sent     = 0;
        bench_errors = 0;
        rng          = 32'hc327;
        repeat (3) @(posedge clk);
        #1;
        arst_n = 1'b1;

        // Aligned words over a full 64-byte packet
        write_packet(PKT1_LEN);
        for (i = 0; i < PKT1_LEN; i += 4) begin
            send_load(i, SZ_W);
        end
        wait_idle();

        // Every size goes to every offset and halves at offset 3 cross into the other bank
        for (i = 0; i < 16; i++) begin
            send_load(i, SZ_H);
            send_load(i, SZ_B);
            send_load(i, SZ_W);
        end
        wait_idle();

        // Loads end right at the length and then one byte past it
        send_load(60, SZ_W);
        send_load(62, SZ_H);
        send_load(63, SZ_B);
        send_load(61, SZ_W);
        send_load(63, SZ_H);
        send_load(64, SZ_B);
        wait_idle();
        // A shorter packet pulls the limit in
        write_packet(PKT2_LEN);
        send_load(26, SZ_W);
        send_load(27, SZ_W);
        send_load(28, SZ_H);
        send_load(29, SZ_H);
        send_load(29, SZ_B);
        send_load(30, SZ_B);
        send_load(60, SZ_W);
        wait_idle();

        // Slots withheld long enough for the queue and the request credits to run dry
        credit_mode = 1;
        fork
            begin
                for (int k = 0; k < 10; k++) begin
                    send_load(2 * k, SZ_H);
                end
            end
            begin
                repeat (40) @(posedge clk);
                #1;
                credit_mode = 0;
            end
        join
        wait_idle();
        check_req_credits();

        // Loads queued while the packet is still arriving
        fork
            write_packet(PKT3_LEN);
            begin
                repeat (3) @(posedge clk);
                #1;
                for (int k = 0; k < 6; k++) begin
                    send_load(7 * k, 2'(k % 3));
                end
            end
        join
        wait_idle();

        // Random loads at full rate with a few of them past the end
        credit_mode = 2;
        for (i = 0; i < N_RANDOM; i++) begin
            rng = xorshift32(rng);
            send_load(int'(rng[15:0]) % (PKT3_LEN + 6), 2'(rng[17:16] % 3));
        end
        wait_idle();
        check_req_credits();
        repeat (4) @(posedge clk);

        $display("Summary: %0d checks, %0d checker errors, %0d bench errors",
            chk_count, chk_errors, bench_errors);
        if (chk_errors == 0 && bench_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Ends a run that stopped making progress
    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d of %0d loads answered",
            cycle_count, resp_count, req_sent);
        $display("Summary: %0d checks, %0d checker errors, %0d bench errors",
            chk_count, chk_errors, bench_errors);
        $display("Regression failed");
        $finish;
    end

endmodule

// ==== bench/load_checker.sv ====
module load_checker (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         beat_valid,
    input  pkt_pkg::pkt_beat_t           beat,
    input  logic                         pkt_ready,
    input  logic [pkt_pkg::PKT_ADDR_W:0] pkt_len,
    input  logic                         req_valid,
    input  pkt_pkg::load_req_t           req,
    input  logic                         resp_credit,
    input  logic                         resp_valid,
    input  pkt_pkg::load_resp_t          resp,
    output int                           errors,
    output int                           checks
);
    timeunit 1ns;
    timeprecision 1ps;
    import pkt_pkg::*;

    // Shadow of the packet bytes with the first byte at index 0
    logic [7:0] shadow [2**PKT_ADDR_W];
    int         shadow_len;
    int         byte_ptr;
    bit         in_pkt;
    // A complete packet is in memory and loads may run
    bit         pkt_done;
    // Response slots the client has filled and not yet freed
    int         slots_used;
    // Requests wait here in arrival order and are answered in that order
    load_req_t  req_q [$];

    initial begin
        errors     = 0;
        checks     = 0;
        shadow_len = 0;
        byte_ptr   = 0;
        in_pkt     = 1'b0;
        pkt_done   = 1'b0;
        slots_used = 0;
    end

    // Expected load result with big-endian bytes, zero padding and zero data flagged past the end
    function automatic load_resp_t ref_load(input logic [PKT_ADDR_W-1:0] addr,
                                            input logic [1:0] size);
        load_resp_t r;
        int         nb;
        int         i;
        nb     = (size == SZ_W) ? 4 : (size == SZ_H) ? 2 : 1;
        r.data = 32'h0;
        r.oor  = (int'(addr) + nb > shadow_len);
        if (!r.oor) begin
            for (i = 0; i < nb; i++) begin
                r.data = {r.data[23:0], shadow[int'(addr) + i]};
            end
        end
        return r;
    endfunction

    task automatic record_beat(input pkt_beat_t b);
        int i;
        // A beat after a finished packet starts the next one at byte zero
        if (!in_pkt) begin
            byte_ptr = 0;
        end
        for (i = 0; i < 4; i++) begin
            shadow[byte_ptr + i] = b.data[31 - 8 * i -: 8];
        end
        byte_ptr = byte_ptr + (b.last ? int'(b.nbytes) : 4);
        in_pkt   = !b.last;
        pkt_done = b.last;
        if (b.last) begin
            shadow_len = byte_ptr;
        end
    endtask

    // Ready and length as they stood before the beat of this cycle lands
    task automatic check_packet_state();
        logic [PKT_ADDR_W:0] exp_len;
        exp_len = shadow_len[PKT_ADDR_W:0];
        if (pkt_ready !== pkt_done) begin
            errors++;
            $display("[FAIL] pkt_ready: got %h, expected %h", pkt_ready, pkt_done);
        end
        if (pkt_len !== exp_len) begin
            errors++;
            $display("[FAIL] pkt_len: got %h, expected %h", pkt_len, exp_len);
        end
    endtask

    task automatic compare_response(input load_resp_t got);
        load_req_t  r;
        load_resp_t exp;
        if (req_q.size() == 0) begin
            errors++;
            $display("A response arrived with no load waiting for it");
        end else begin
            r   = req_q.pop_front();
            exp = ref_load(r.addr, r.size);
            checks++;
            if (got.data !== exp.data) begin
                errors++;
                $display("[FAIL] resp.data addr %h size %h: got %h, expected %h",
                    r.addr, r.size, got.data, exp.data);
            end
            if (got.oor !== exp.oor) begin
                errors++;
                $display("[FAIL] resp.oor addr %h size %h: got %h, expected %h",
                    r.addr, r.size, got.oor, exp.oor);
            end
        end
    endtask

    // The expected value is worked out on return because a load reads the packet present at issue
    always @(posedge clk) begin
        if (arst_n) begin
            check_packet_state();
            if (beat_valid) begin
                record_beat(beat);
            end
            if (req_valid) begin
                req_q.push_back(req);
            end
            slots_used = slots_used - int'(resp_credit) + int'(resp_valid);
            if (slots_used > RESP_CREDITS) begin
                errors++;
                $display("More responses arrived than the client had slots for");
            end
            if (resp_valid) begin
                compare_response(resp);
            end
        end
    end

endmodule

// ==== logic/packet_load_top.sv ====
module packet_load_top (
    input  logic                         clk,
    input  logic                         arst_n,
    input  logic                         beat_valid,
    input  pkt_pkg::pkt_beat_t           beat,
    output logic                         pkt_ready,
    output logic [pkt_pkg::PKT_ADDR_W:0] pkt_len,
    input  logic                         req_valid,
    input  pkt_pkg::load_req_t           req,
    output logic                         req_credit,
    input  logic                         resp_credit,
    output logic                         resp_valid,
    output pkt_pkg::load_resp_t          resp
);
    import pkt_pkg::*;

    // Writer to memory
    logic                   wr_en;
    mem_wr_t                wr;

    // Load unit, adapter and memory read path
    logic [PKT_ADDR_W-1:0]  rd_addr;
    logic [1:0]             rd_size;
    logic [WORD_ADDR_W-1:0] rd_word_addr;
    logic [63:0]            bigword;
    logic [31:0]            rd_data;

    packet_writer i_packet_writer (
        .clk        (clk),
        .arst_n     (arst_n),
        .beat_valid (beat_valid),
        .beat       (beat),
        .wr_en      (wr_en),
        .wr         (wr),
        .pkt_ready  (pkt_ready),
        .pkt_len    (pkt_len)
    );

    packet_mem i_packet_mem (
        .clk          (clk),
        .wr_en        (wr_en),
        .wr           (wr),
        .rd_word_addr (rd_word_addr),
        .bigword      (bigword)
    );

    read_size_adapter i_read_size_adapter (
        .clk       (clk),
        .arst_n    (arst_n),
        .byte_addr (rd_addr),
        .size      (rd_size),
        .word_addr (rd_word_addr),
        .bigword   (bigword),
        .data      (rd_data)
    );

    load_unit i_load_unit (
        .clk         (clk),
        .arst_n      (arst_n),
        .req_valid   (req_valid),
        .req         (req),
        .req_credit  (req_credit),
        .resp_credit (resp_credit),
        .resp_valid  (resp_valid),
        .resp        (resp),
        .pkt_ready   (pkt_ready),
        .pkt_len     (pkt_len),
        .rd_addr     (rd_addr),
        .rd_size     (rd_size),
        .rd_data     (rd_data)
    );

endmodule

// ==== logic/load_unit.sv ====
module load_unit (
    input  logic                           clk,
    input  logic                           arst_n,
    input  logic                           req_valid,
    input  pkt_pkg::load_req_t             req,
    output logic                           req_credit,
    input  logic                           resp_credit,
    output logic                           resp_valid,
    output pkt_pkg::load_resp_t            resp,
    input  logic                           pkt_ready,
    input  logic [pkt_pkg::PKT_ADDR_W:0]   pkt_len,
    output logic [pkt_pkg::PKT_ADDR_W-1:0] rd_addr,
    output logic [1:0]                     rd_size,
    input  logic [31:0]                    rd_data
);
    import pkt_pkg::*;

    // Request queue
    load_req_t             q_mem [REQ_CREDITS];
    logic [REQ_PTR_W-1:0]  wr_ptr;
    logic [REQ_PTR_W-1:0]  rd_ptr;
    logic [REQ_CNT_W-1:0]  q_cnt;
    load_req_t             head;

    // Response slots still granted by the client
    logic [RESP_CNT_W-1:0] resp_cnt;

    logic                  issue;
    logic [2:0]            size_bytes;
    logic [PKT_ADDR_W:0]   end_addr;
    logic                  oor;

    // First in-flight stage, the memory read is underway
    logic                  s1_valid;
    logic                  s1_oor;

    assign head = q_mem[rd_ptr];

    // A load waits for a complete packet, a queued request and a free response slot
    assign issue = pkt_ready && (q_cnt != '0) && (resp_cnt != '0);

    always_comb begin
        case (head.size)
            SZ_H:    size_bytes = 3'd2;
            SZ_B:    size_bytes = 3'd1;
            default: size_bytes = 3'd4;
        endcase
    end

    // One past the last byte the load touches, compared against the length
    assign end_addr = {1'b0, head.addr} + {{(PKT_ADDR_W - 2){1'b0}}, size_bytes};
    assign oor      = end_addr > pkt_len;

    // The size is only driven with a live request behind it
    assign rd_addr = head.addr;
    assign rd_size = issue ? head.size : SZ_W;

    always_ff @(posedge clk) begin
        if (req_valid) begin
            q_mem[wr_ptr] <= req;
        end
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            q_cnt      <= '0;
            resp_cnt   <= RESP_CNT_W'(RESP_CREDITS);
            req_credit <= 1'b0;
        end else begin
            if (req_valid) begin
                wr_ptr <= wr_ptr + REQ_PTR_W'(1);
            end
            if (issue) begin
                rd_ptr <= rd_ptr + REQ_PTR_W'(1);
            end
            q_cnt    <= q_cnt + REQ_CNT_W'(req_valid) - REQ_CNT_W'(issue);
            resp_cnt <= resp_cnt + RESP_CNT_W'(resp_credit) - RESP_CNT_W'(issue);
            // Each pop frees a queue entry and hands a request credit back
            req_credit <= issue;
        end
    end

    // Valid flags of the two in-flight stages
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            s1_valid   <= 1'b0;
            resp_valid <= 1'b0;
        end else begin
            s1_valid   <= issue;
            resp_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_oor <= oor;
    end

    // Adapter data is valid in the cycle after issue and is captured here
    always_ff @(posedge clk) begin
        if (s1_valid) begin
            resp.data <= s1_oor ? 32'h0 : rd_data;
            resp.oor  <= s1_oor;
        end
    end

    // The client only sends while it holds a request credit
    a_q_no_overflow : assert property (@(posedge clk) disable iff (!arst_n)
        req_valid |-> q_cnt < REQ_CNT_W'(REQ_CREDITS));

    // The client never returns more slots than it granted
    a_resp_cnt_max : assert property (@(posedge clk) disable iff (!arst_n)
        resp_cnt <= RESP_CNT_W'(RESP_CREDITS));

endmodule

// ==== logic/read_size_adapter.sv ====
module read_size_adapter (
    input  logic                            clk,
    input  logic                            arst_n,
    input  logic [pkt_pkg::PKT_ADDR_W-1:0]  byte_addr,
    input  logic [1:0]                      size,
    output logic [pkt_pkg::WORD_ADDR_W-1:0] word_addr,
    input  logic [63:0]                     bigword,
    output logic [31:0]                     data
);
    import pkt_pkg::*;

    // Byte offset and size line up with the memory's registered word pair
    logic [1:0]  offset_q;
    logic [1:0]  size_q;
    logic [31:0] selected;

    // The memory sees the word address in the issue cycle itself
    assign word_addr = byte_addr[PKT_ADDR_W-1:2];

    // Latched on the same edge that the memory latches its read
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            offset_q <= '0;
            size_q   <= SZ_W;
        end else begin
            offset_q <= byte_addr[1:0];
            size_q   <= size;
        end
    end

    // Four bytes starting at the offset, counted from the top byte of the pair
    always_comb begin
        case (offset_q)
            2'd0:    selected = bigword[63:32];
            2'd1:    selected = bigword[55:24];
            2'd2:    selected = bigword[47:16];
            default: selected = bigword[39:8];
        endcase
    end

    // Smaller loads keep the leading bytes and move them down to the low end
    always_comb begin
        case (size_q)
            SZ_W:    data = selected;
            SZ_H:    data = {16'h0000, selected[31:16]};
            SZ_B:    data = {24'h000000, selected[31:24]};
            default: data = '0;
        endcase
    end

    // The load unit only ever presents a real BPF size when it issues
    a_legal_size : assert property (@(posedge clk) disable iff (!arst_n)
        size != 2'd3);

endmodule

// ==== logic/packet_mem.sv ====
module packet_mem (
    input  logic                           clk,
    input  logic                           wr_en,
    input  pkt_pkg::mem_wr_t               wr,
    input  logic [pkt_pkg::WORD_ADDR_W-1:0] rd_word_addr,
    output logic [63:0]                    bigword
);
    import pkt_pkg::*;

    // Even words live in one bank and odd words in the other
    logic [31:0] even_bank [2**BANK_ADDR_W];
    logic [31:0] odd_bank  [2**BANK_ADDR_W];

    logic                   wr_odd;
    logic [BANK_ADDR_W-1:0] wr_bank_addr;

    logic                   rd_odd;
    logic [BANK_ADDR_W-1:0] rd_bank_addr;
    logic [BANK_ADDR_W-1:0] even_rd_addr;
    logic [BANK_ADDR_W-1:0] odd_rd_addr;
    logic                   even_fwd;
    logic                   odd_fwd;

    logic [31:0] even_q;
    logic [31:0] odd_q;
    logic        rd_odd_q;

    assign wr_odd       = wr.addr[0];
    assign wr_bank_addr = wr.addr[WORD_ADDR_W-1:1];

    assign rd_odd       = rd_word_addr[0];
    assign rd_bank_addr = rd_word_addr[WORD_ADDR_W-1:1];

    // For an even word w, w and w+1 share a bank row
    // For an odd word w, w+1 is in the next row of the even bank
    assign even_rd_addr = rd_odd ? rd_bank_addr + BANK_ADDR_W'(1) : rd_bank_addr;
    assign odd_rd_addr  = rd_bank_addr;

    // A read on the same edge as the write of its word sees the new data
    // This covers a load issued the very cycle pkt_ready rises
    assign even_fwd = wr_en && !wr_odd && (wr_bank_addr == even_rd_addr);
    assign odd_fwd  = wr_en && wr_odd && (wr_bank_addr == odd_rd_addr);

    always_ff @(posedge clk) begin
        if (wr_en && !wr_odd) begin
            even_bank[wr_bank_addr] <= wr.data;
        end
        if (wr_en && wr_odd) begin
            odd_bank[wr_bank_addr] <= wr.data;
        end
    end

    always_ff @(posedge clk) begin
        even_q   <= even_fwd ? wr.data : even_bank[even_rd_addr];
        odd_q    <= odd_fwd ? wr.data : odd_bank[odd_rd_addr];
        rd_odd_q <= rd_odd;
    end

    // Word w goes in the upper half whichever bank it came from
    assign bigword = rd_odd_q ? {odd_q, even_q} : {even_q, odd_q};

endmodule

// ==== logic/packet_writer.sv ====
module packet_writer (
    input  logic                       clk,
    input  logic                       arst_n,
    input  logic                       beat_valid,
    input  pkt_pkg::pkt_beat_t         beat,
    output logic                       wr_en,
    output pkt_pkg::mem_wr_t           wr,
    output logic                       pkt_ready,
    output logic [pkt_pkg::PKT_ADDR_W:0] pkt_len
);
    import pkt_pkg::*;

    // High between the first and the last beat of a packet
    logic                   in_pkt;
    // Word address the next beat of the current packet goes to
    logic [WORD_ADDR_W-1:0] word_ptr;
    // Bytes received so far in the current packet
    logic [PKT_ADDR_W:0]    len_acc;

    logic [WORD_ADDR_W-1:0] beat_addr;
    logic [PKT_ADDR_W:0]    len_base;
    logic [2:0]             beat_bytes;
    logic [PKT_ADDR_W:0]    len_next;

    // A beat outside a packet starts a new one at word zero with an empty length
    assign beat_addr = in_pkt ? word_ptr : '0;
    assign len_base  = in_pkt ? len_acc : '0;

    // Every beat but the last is a full word
    assign beat_bytes = beat.last ? beat.nbytes : 3'd4;
    assign len_next   = len_base + {{(PKT_ADDR_W - 2){1'b0}}, beat_bytes};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            in_pkt    <= 1'b0;
            word_ptr  <= '0;
            len_acc   <= '0;
            wr_en     <= 1'b0;
            pkt_ready <= 1'b0;
            pkt_len   <= '0;
        end else begin
            wr_en <= beat_valid;
            if (beat_valid) begin
                word_ptr  <= beat_addr + WORD_ADDR_W'(1);
                len_acc   <= len_next;
                in_pkt    <= !beat.last;
                // Loads are held off from the first beat until the packet is complete
                pkt_ready <= beat.last;
                if (beat.last) begin
                    pkt_len <= len_next;
                end
            end
        end
    end

    // The write trails its beat by one cycle
    always_ff @(posedge clk) begin
        if (beat_valid) begin
            wr.addr <= beat_addr;
            wr.data <= beat.data;
        end
    end

    // The producer must mark how many bytes of the closing beat are real
    a_last_nbytes : assert property (@(posedge clk) disable iff (!arst_n)
        beat_valid && beat.last |-> beat.nbytes inside {[3'd1:3'd4]});

endmodule

// ==== logic/pkt_pkg.sv ====
package pkt_pkg;

    // Byte address width of the packet memory, 4 KiB of packet space
    localparam int PKT_ADDR_W = 12;

    // Word address drops the two byte-lane bits
    localparam int WORD_ADDR_W = PKT_ADDR_W - 2;

    // Each bank holds every other word, so one more bit goes away
    localparam int BANK_ADDR_W = WORD_ADDR_W - 1;

    // BPF load size codes as they appear in the opcode size field
    localparam logic [1:0] SZ_W = 2'd0;
    localparam logic [1:0] SZ_H = 2'd1;
    localparam logic [1:0] SZ_B = 2'd2;

    // Request queue depth, equal to the client's starting request credits
    // The queue pointers wrap on their own, so this stays a power of two
    localparam int REQ_CREDITS = 4;

    // Response slots the client grants to the load unit out of reset
    localparam int RESP_CREDITS = 2;

    // Counter and pointer widths derived from the credit counts
    localparam int REQ_PTR_W  = $clog2(REQ_CREDITS);
    localparam int REQ_CNT_W  = $clog2(REQ_CREDITS + 1);
    localparam int RESP_CNT_W = $clog2(RESP_CREDITS + 1);

    // One beat from the packet producer
    // The first packet byte sits in data[31:24]
    // nbytes is only looked at when last is set and must be 1 to 4
    typedef struct packed {
        logic [31:0] data;
        logic        last;
        logic [2:0]  nbytes;
    } pkt_beat_t;

    // A load request from the client, byte addressed at any alignment
    typedef struct packed {
        logic [PKT_ADDR_W-1:0] addr;
        logic [1:0]            size;
    } load_req_t;

    // A load result, right-justified and zero-padded on the left
    // oor is set when the load ran past the packet length
    typedef struct packed {
        logic [31:0] data;
        logic        oor;
    } load_resp_t;

    // One word write into the packet memory
    typedef struct packed {
        logic [WORD_ADDR_W-1:0] addr;
        logic [31:0]            data;
    } mem_wr_t;

endpackage
